//--- Bender.yml
package:
  name: id_stage

sources:
  - files:
      - id_pkg.sv
      - id_decoder.sv
      - id_pipe_reg.sv
      - id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_id_stage.sv

//--- id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_t   inst_i,
    output id_pkg::id_dec_t dec_o
);

    id_pkg::id_opcode_e    opcode;
    logic [6:0]            funct7;
    id_pkg::reg_addr_t     rd;
    id_pkg::reg_addr_t     rs1;
    id_pkg::reg_addr_t     rs2;
    id_pkg::id_f3_muldiv_e f3_muldiv;
    id_pkg::id_f3_load_e   f3_load;
    id_pkg::id_f3_store_e  f3_store;
    id_pkg::id_f3_branch_e f3_branch;

    logic valid;
    logic r1_re;
    logic r2_re;
    logic rd_we;
    logic mem_re;
    logic mem_we;

    assign opcode = id_pkg::id_opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    // one funct3 field, viewed per class
    assign f3_muldiv = id_pkg::id_f3_muldiv_e'(inst_i[14:12]);
    assign f3_load   = id_pkg::id_f3_load_e'(inst_i[14:12]);
    assign f3_store  = id_pkg::id_f3_store_e'(inst_i[14:12]);
    assign f3_branch = id_pkg::id_f3_branch_e'(inst_i[14:12]);

    always_comb begin
        valid  = 1'b0;
        r1_re  = 1'b0;
        r2_re  = 1'b0;
        rd_we  = 1'b0;
        mem_re = 1'b0;
        mem_we = 1'b0;

        case (opcode)
            id_pkg::OP_IMM: begin
                valid = 1'b1; // all eight funct3 codes legal
                r1_re = 1'b1;
                rd_we = 1'b1;
            end
            id_pkg::OP_REG: begin
                if (funct7 == id_pkg::F7_BASE || funct7 == id_pkg::F7_ALT) begin
                    valid = 1'b1;
                    r1_re = 1'b1;
                    r2_re = 1'b1;
                    rd_we = 1'b1;
                end else if (funct7 == id_pkg::F7_MULDIV) begin
                    valid = 1'b1;
                    r1_re = 1'b1;
                    r2_re = 1'b1;
                    case (f3_muldiv)
                        id_pkg::F3_MUL,
                        id_pkg::F3_MULH,
                        id_pkg::F3_MULHSU,
                        id_pkg::F3_MULHU: rd_we = 1'b1;
                        default:          rd_we = 1'b0; // div/rem write back later
                    endcase
                end
            end
            id_pkg::OP_LOAD: begin
                case (f3_load)
                    id_pkg::F3_LB, id_pkg::F3_LH, id_pkg::F3_LW,
                    id_pkg::F3_LBU, id_pkg::F3_LHU: begin
                        valid  = 1'b1;
                        r1_re  = 1'b1;
                        rd_we  = 1'b1;
                        mem_re = 1'b1;
                    end
                    default: valid = 1'b0;
                endcase
            end
            id_pkg::OP_STORE: begin
                case (f3_store)
                    id_pkg::F3_SB, id_pkg::F3_SH: begin
                        valid  = 1'b1;
                        r1_re  = 1'b1;
                        r2_re  = 1'b1;
                        mem_re = 1'b1; // partial word, read-modify-write
                        mem_we = 1'b1;
                    end
                    id_pkg::F3_SW: begin
                        valid  = 1'b1;
                        r1_re  = 1'b1;
                        r2_re  = 1'b1;
                        mem_we = 1'b1;
                    end
                    default: valid = 1'b0;
                endcase
            end
            id_pkg::OP_BRANCH: begin
                case (f3_branch)
                    id_pkg::F3_BEQ, id_pkg::F3_BNE, id_pkg::F3_BLT,
                    id_pkg::F3_BGE, id_pkg::F3_BLTU, id_pkg::F3_BGEU: begin
                        valid = 1'b1;
                        r1_re = 1'b1;
                        r2_re = 1'b1;
                    end
                    default: valid = 1'b0;
                endcase
            end
            id_pkg::OP_JAL, id_pkg::OP_LUI, id_pkg::OP_AUIPC: begin
                valid = 1'b1;
                rd_we = 1'b1;
            end
            id_pkg::OP_JALR: begin
                valid = 1'b1;
                r1_re = 1'b1;
                rd_we = 1'b1;
            end
            id_pkg::OP_FENCE, id_pkg::OP_NOP: begin
                valid = 1'b1; // no side effects here
            end
            default: valid = 1'b0;
        endcase
    end

    // addresses always follow the fields, enables qualify them
    always_comb begin
        dec_o.valid         = valid;
        dec_o.rf.reg1_re    = r1_re;
        dec_o.rf.reg1_raddr = rs1;
        dec_o.rf.reg2_re    = r2_re;
        dec_o.rf.reg2_raddr = rs2;
        dec_o.rf.reg_we     = rd_we;
        dec_o.rf.reg_waddr  = rd;
        dec_o.mem.sram_re   = mem_re;
        dec_o.mem.sram_we   = mem_we;
    end

endmodule

//--- id_pipe_reg.sv
`timescale 1ns/1ps

module id_pipe_reg #(
    parameter int ADDR_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  id_pkg::inst_t        inst_i,
    input  logic [ADDR_W-1:0]    inst_addr_i,
    input  id_pkg::id_dec_t      dec_i,
    input  logic                 halt_i,
    input  logic                 int_i,
    input  logic                 jump_i,
    input  logic                 hold_i,
    output id_pkg::inst_t        inst_o,
    output logic [ADDR_W-1:0]    inst_addr_o,
    output logic                 inst_valid_o,
    output id_pkg::id_rf_ctrl_t  rf_ctrl_o,
    output id_pkg::id_mem_ctrl_t mem_ctrl_o
);

    logic not_nop;
    logic bubble;

    assign not_nop = (inst_i != id_pkg::NOP_WORD);

    // halt > int > jump > hold
    always_comb begin
        if (halt_i) begin
            bubble = 1'b1;
        end else if (int_i && not_nop) begin
            bubble = 1'b1;
        end else if (jump_i && not_nop) begin
            bubble = 1'b1;
        end else if (hold_i) begin
            bubble = 1'b1;
        end else begin
            bubble = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_o       <= '0;
            inst_addr_o  <= '0;
            inst_valid_o <= 1'b0;
            rf_ctrl_o    <= '0;
            mem_ctrl_o   <= '0;
        end else if (bubble) begin
            inst_o       <= id_pkg::NOP_WORD;
            inst_valid_o <= 1'b1;
            rf_ctrl_o    <= '0; // enables and addresses cleared
            mem_ctrl_o   <= '0;
            // inst_addr_o holds
        end else begin
            inst_o       <= inst_i;
            inst_addr_o  <= inst_addr_i;
            inst_valid_o <= dec_i.valid;
            rf_ctrl_o    <= dec_i.rf;
            mem_ctrl_o   <= dec_i.mem;
        end
    end

endmodule

//--- id_pkg.sv
package id_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, OP_NOP is local to this core
    typedef enum logic [6:0] {
        OP_NOP    = 7'b0000001,
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } id_opcode_e;

    // shared by OP_REG and OP_IMM (ADDI, SRI)
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } id_f3_alu_e;

    typedef enum logic [2:0] {
        F3_MUL    = 3'b000,
        F3_MULH   = 3'b001,
        F3_MULHSU = 3'b010,
        F3_MULHU  = 3'b011,
        F3_DIV    = 3'b100,
        F3_DIVU   = 3'b101,
        F3_REM    = 3'b110,
        F3_REMU   = 3'b111
    } id_f3_muldiv_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } id_f3_load_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } id_f3_store_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } id_f3_branch_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam inst_t NOP_WORD = 32'h0000_0001; // bubble word

    typedef struct packed {
        logic      reg1_re;
        reg_addr_t reg1_raddr;
        logic      reg2_re;
        reg_addr_t reg2_raddr;
        logic      reg_we;
        reg_addr_t reg_waddr;
    } id_rf_ctrl_t;

    typedef struct packed {
        logic sram_re;
        logic sram_we;
    } id_mem_ctrl_t;

    typedef struct packed {
        logic         valid;
        id_rf_ctrl_t  rf;
        id_mem_ctrl_t mem;
    } id_dec_t;

endpackage

//--- id_stage.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_pipe_reg.sv
id_stage.sv
tb_id_stage.sv

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage #(
    parameter int ADDR_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  id_pkg::inst_t        inst_i,
    input  logic [ADDR_W-1:0]    inst_addr_i,
    input  logic                 halt_i,    // from mem stage
    input  logic                 int_i,     // from ex
    input  logic                 jump_i,
    input  logic                 hold_i,
    output id_pkg::inst_t        inst_o,
    output logic [ADDR_W-1:0]    inst_addr_o,
    output logic                 inst_valid_o,
    output id_pkg::id_rf_ctrl_t  rf_ctrl_o,
    output id_pkg::id_mem_ctrl_t mem_ctrl_o
);

    id_pkg::id_dec_t dec;

    id_decoder i_id_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    id_pipe_reg #(
        .ADDR_W (ADDR_W)
    ) i_id_pipe_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .dec_i        (dec),
        .halt_i       (halt_i),
        .int_i        (int_i),
        .jump_i       (jump_i),
        .hold_i       (hold_i),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o),
        .rf_ctrl_o    (rf_ctrl_o),
        .mem_ctrl_o   (mem_ctrl_o)
    );

endmodule

//--- tb_id_ref.svh
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

localparam logic [6:0] OPC_NOP    = 7'b0000001;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_FENCE  = 7'b0001111;
localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_REG    = 7'b0110011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;

typedef struct packed {
    id_pkg::inst_t        inst;
    logic [ADDR_W-1:0]    addr;
    logic                 valid;
    id_pkg::id_rf_ctrl_t  rf;
    id_pkg::id_mem_ctrl_t mem;
} exp_out_t;

logic [31:0] rng_state;

function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

// upper half only, low lcg bits repeat quickly
function automatic logic [15:0] rand_hi();
    logic [31:0] r;
    r = next_rand();
    return r[31:16];
endfunction

function automatic id_pkg::inst_t pack_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic id_pkg::inst_t gen_inst();
    logic [31:0] body;
    logic [6:0]  op;
    logic [6:0]  f7;
    logic [3:0]  cls;
    body = next_rand();
    if (rand_hi() % 8 == 0) begin
        return body; // anything goes, illegal codes included
    end
    cls = 4'(rand_hi() % 13);
    f7  = body[31:25];
    case (cls)
        4'd0:  op = OPC_IMM;
        4'd1: begin
            op = OPC_REG;
            f7 = body[31] ? 7'b0100000 : 7'b0000000;
        end
        4'd2: begin
            op = OPC_REG;
            f7 = 7'b0000001; // mul/div group
        end
        4'd3:  op = OPC_REG; // random funct7, mostly illegal
        4'd4:  op = OPC_LOAD;
        4'd5:  op = OPC_STORE;
        4'd6:  op = OPC_BRANCH;
        4'd7:  op = OPC_JAL;
        4'd8:  op = OPC_JALR;
        4'd9:  op = OPC_LUI;
        4'd10: op = OPC_AUIPC;
        4'd11: op = OPC_FENCE;
        default: op = OPC_NOP; // nop opcode, random upper bits
    endcase
    return {f7, body[24:7], op};
endfunction

function automatic exp_out_t ref_out(input id_pkg::inst_t w, input logic [ADDR_W-1:0] a,
                                     input logic halt, input logic intr, input logic jmp,
                                     input logic hold, input logic [ADDR_W-1:0] prev_addr);
    exp_out_t   e;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       v;
    logic       r1;
    logic       r2;
    logic       we;
    logic       mre;
    logic       mwe;
    logic       bubble;
    f3 = w[14:12];
    f7 = w[31:25];
    {v, r1, r2, we, mre, mwe} = '0;
    case (w[6:0])
        OPC_IMM: {v, r1, we} = 3'b111;
        OPC_REG: begin
            if (f7 == 7'b0000000 || f7 == 7'b0100000) begin
                {v, r1, r2, we} = 4'b1111;
            end else if (f7 == 7'b0000001) begin
                {v, r1, r2, we} = {3'b111, ~f3[2]}; // div/rem write back later
            end
        end
        OPC_LOAD: begin
            if (f3 != 3'b011 && f3 < 3'b110) begin
                {v, r1, we, mre} = 4'b1111;
            end
        end
        OPC_STORE: begin
            if (f3 <= 3'b010) begin
                {v, r1, r2, mwe} = 4'b1111;
                mre = (f3 != 3'b010); // sb, sh need the old word
            end
        end
        OPC_BRANCH: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                {v, r1, r2} = 3'b111;
            end
        end
        OPC_JAL, OPC_LUI, OPC_AUIPC: {v, we} = 2'b11;
        OPC_JALR: {v, r1, we} = 3'b111;
        OPC_FENCE, OPC_NOP: v = 1'b1;
        default: v = 1'b0;
    endcase
    if (halt) begin
        bubble = 1'b1;
    end else if (intr && w != id_pkg::NOP_WORD) begin
        bubble = 1'b1;
    end else if (jmp && w != id_pkg::NOP_WORD) begin
        bubble = 1'b1;
    end else begin
        bubble = hold;
    end
    e = '0;
    if (bubble) begin
        e.inst  = id_pkg::NOP_WORD;
        e.valid = 1'b1;
        e.addr  = prev_addr; // address holds through a bubble
    end else begin
        e.inst          = w;
        e.addr          = a;
        e.valid         = v;
        e.rf.reg1_re    = r1;
        e.rf.reg1_raddr = w[19:15];
        e.rf.reg2_re    = r2;
        e.rf.reg2_raddr = w[24:20];
        e.rf.reg_we     = we;
        e.rf.reg_waddr  = w[11:7];
        e.mem.sram_re   = mre;
        e.mem.sram_we   = mwe;
    end
    return e;
endfunction

`endif

//--- tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    localparam int ADDR_W      = 32;
    localparam int N_RST       = 10;
    localparam int N_DIR       = 12;
    localparam int N_VEC       = 600;
    localparam int TIMEOUT_CYC = N_RST + N_DIR + N_VEC + 78;

    `include "tb_id_ref.svh"

    logic                 clk;
    logic                 rst_n_i;
    id_pkg::inst_t        inst_i;
    logic [ADDR_W-1:0]    inst_addr_i;
    logic                 halt_i;
    logic                 int_i;
    logic                 jump_i;
    logic                 hold_i;
    id_pkg::inst_t        inst_o;
    logic [ADDR_W-1:0]    inst_addr_o;
    logic                 inst_valid_o;
    id_pkg::id_rf_ctrl_t  rf_ctrl_o;
    id_pkg::id_mem_ctrl_t mem_ctrl_o;

    exp_out_t          exp_q[$];
    logic [ADDR_W-1:0] exp_addr;
    int                n_sent;
    int                n_checked;
    int                n_errors;
    int                cycle_cnt;

    id_stage #(
        .ADDR_W (ADDR_W)
    ) i_id_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .halt_i       (halt_i),
        .int_i        (int_i),
        .jump_i       (jump_i),
        .hold_i       (hold_i),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o),
        .rf_ctrl_o    (rf_ctrl_o),
        .mem_ctrl_o   (mem_ctrl_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic one_in(input int n);
        return (rand_hi() % n) == 0;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            n_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic apply_vec(input id_pkg::inst_t w, input logic [ADDR_W-1:0] a,
                             input logic f_halt, input logic f_int,
                             input logic f_jump, input logic f_hold);
        exp_out_t e;
        @(negedge clk);
        rst_n_i     = 1'b1;
        inst_i      = w;
        inst_addr_i = a;
        halt_i      = f_halt;
        int_i       = f_int;
        jump_i      = f_jump;
        hold_i      = f_hold;
        e = ref_out(w, a, f_halt, f_int, f_jump, f_hold, exp_addr);
        exp_addr = e.addr;
        exp_q.push_back(e);
        n_sent++;
    endtask

    initial begin : stimulus
        id_pkg::inst_t     w;
        logic [ADDR_W-1:0] a;
        logic              fh;
        logic              fi;
        logic              fj;
        logic              fd;
        rng_state   = 32'h2e76b3c1;
        rst_n_i     = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        halt_i      = 1'b0;
        int_i       = 1'b0;
        jump_i      = 1'b0;
        hold_i      = 1'b0;
        exp_addr    = '0;
        // inputs keep moving while reset is held
        repeat (N_RST) begin
            @(negedge clk);
            inst_i      = gen_inst();
            inst_addr_i = next_rand();
            halt_i      = one_in(8);
            hold_i      = one_in(8);
            exp_q.push_back('0);
            n_sent++;
        end
        apply_vec(32'h0000_0000, 32'h100, 1'b0, 1'b0, 1'b0, 1'b0); // illegal, valid stays 0
        apply_vec(pack_word(7'h01, 5'd2, 5'd1, 3'b100, 5'd3, OPC_REG), 32'h104,
                  1'b0, 1'b0, 1'b0, 1'b0); // div
        apply_vec(pack_word(7'h01, 5'd5, 5'd4, 3'b110, 5'd6, OPC_REG), 32'h108,
                  1'b0, 1'b0, 1'b0, 1'b0); // rem
        apply_vec(pack_word(7'h01, 5'd8, 5'd7, 3'b000, 5'd9, OPC_REG), 32'h10c,
                  1'b0, 1'b0, 1'b0, 1'b0); // mul
        apply_vec(pack_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd4, OPC_STORE), 32'h110,
                  1'b0, 1'b0, 1'b0, 1'b0); // sb
        apply_vec(pack_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd4, OPC_STORE), 32'h114,
                  1'b0, 1'b0, 1'b0, 1'b0); // sh
        apply_vec(pack_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd4, OPC_STORE), 32'h118,
                  1'b0, 1'b0, 1'b0, 1'b0); // sw
        apply_vec(id_pkg::NOP_WORD, 32'h11c, 1'b1, 1'b0, 1'b0, 1'b0);
        apply_vec(id_pkg::NOP_WORD, 32'h120, 1'b0, 1'b1, 1'b1, 1'b0); // passes through
        apply_vec(pack_word(7'h20, 5'd3, 5'd2, 3'b000, 5'd1, OPC_REG), 32'h124,
                  1'b0, 1'b0, 1'b1, 1'b0);
        apply_vec(pack_word(7'h00, 5'd3, 5'd2, 3'b111, 5'd1, OPC_REG), 32'h128,
                  1'b1, 1'b1, 1'b1, 1'b1);
        apply_vec(pack_word(7'h00, 5'd0, 5'd2, 3'b010, 5'd7, OPC_LOAD), 32'h12c,
                  1'b0, 1'b0, 1'b0, 1'b1);
        for (int k = 0; k < N_VEC; k++) begin
            if (one_in(6)) begin
                w = id_pkg::NOP_WORD;
            end else begin
                w = gen_inst();
            end
            a       = next_rand();
            a[1:0]  = 2'b00;
            fh      = one_in(8);
            fi      = one_in(8);
            fj      = one_in(8);
            fd      = one_in(8);
            apply_vec(w, a, fh, fi, fj, fd);
        end
        wait (n_checked == n_sent);
        #1;
        $display("%0d checks, %0d errors", n_checked, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // outputs settle well before the next falling edge
    always begin : compare_proc
        exp_out_t e;
        @(posedge clk);
        #2;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            compare_field("inst_o", e.inst, inst_o);
            compare_field("inst_addr_o", e.addr, inst_addr_o);
            compare_field("inst_valid_o", 32'(e.valid), 32'(inst_valid_o));
            compare_field("reg1_re", 32'(e.rf.reg1_re), 32'(rf_ctrl_o.reg1_re));
            compare_field("reg1_raddr", 32'(e.rf.reg1_raddr), 32'(rf_ctrl_o.reg1_raddr));
            compare_field("reg2_re", 32'(e.rf.reg2_re), 32'(rf_ctrl_o.reg2_re));
            compare_field("reg2_raddr", 32'(e.rf.reg2_raddr), 32'(rf_ctrl_o.reg2_raddr));
            compare_field("reg_we", 32'(e.rf.reg_we), 32'(rf_ctrl_o.reg_we));
            compare_field("reg_waddr", 32'(e.rf.reg_waddr), 32'(rf_ctrl_o.reg_waddr));
            compare_field("sram_re", 32'(e.mem.sram_re), 32'(mem_ctrl_o.sram_re));
            compare_field("sram_we", 32'(e.mem.sram_we), 32'(mem_ctrl_o.sram_we));
            n_checked++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC) begin
            $display("run timed out after %0d cycles without finishing", TIMEOUT_CYC);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule
